/* filelist.f */
+incdir+.
axiLitePkg.sv
axiChanBuf.sv
apbCmdRegs.sv
axiLiteMaster.sv
axiLiteMemSlave.sv
axiLiteSubsys.sv
tbAxiLiteSubsys.sv

/* Makefile */
SRCS := $(filter %.sv,$(shell cat filelist.f)) axiLite_defs.svh

.PHONY: run clean

run: obj_dir/VtbAxiLiteSubsys
	@out="$$(./obj_dir/VtbAxiLiteSubsys)"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

obj_dir/VtbAxiLiteSubsys: $(SRCS) filelist.f
	verilator --binary -j 0 -f filelist.f --top-module tbAxiLiteSubsys

clean:
	rm -rf obj_dir

/* tbAxiLiteSubsys.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axiLite_defs.svh"

module tbAxiLiteSubsys import axiLitePkg::*; ();

  localparam int NumRandom = 40;
  localparam int WinWords  = 16;
  localparam int CmdCycles = 60;
  // Random and fill commands plus about 24 directed ones, and the reset
  localparam int MaxCycles = (NumRandom + WinWords + 24) * CmdCycles + 200;

  logic   aclk;
  logic   arstN;
  apbReqT apbReq;
  apbRspT apbRsp;

  logic [`AXI_DATA_W-1:0] modelMem [`MEM_WORDS];
  logic [`AXI_DATA_W-1:0] expRdata;
  cmdRespT                expQ[$];
  cmdRespT                obsQ[$];
  int                     tagQ[$];
  int                     cmdCount;
  int                     checks;
  int                     errors;
  int                     cycles;

  axiLiteSubsys i_axiLiteSubsys (
    .aclk(aclk), .arstN(arstN),
    .apbReq(apbReq), .apbRsp(apbRsp)
  );

  always #4 aclk = ~aclk;

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Checks: %0d  Errors: %0d", checks, errors);
      $display("Simulation failed");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB transfers with a setup and an access cycle, sampled mid access
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
    @(negedge aclk);
    apbReq.paddr   = addr;
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite  = 1'b1;
    apbReq.pwdata  = data;
    @(negedge aclk);
    apbReq.penable = 1'b1;
    #2;
    err = apbRsp.pslverr;
    checks++;
    if (!apbRsp.pready) begin
      errors++;
      $display("Error at %0t: pready was low in an APB write access cycle", $time);
    end
    @(negedge aclk);
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge aclk);
    apbReq.paddr   = addr;
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    apbReq.pwrite  = 1'b0;
    @(negedge aclk);
    apbReq.penable = 1'b1;
    #2;
    data = apbRsp.prdata;
    err  = apbRsp.pslverr;
    checks++;
    if (!apbRsp.pready) begin
      errors++;
      $display("Error at %0t: pready was low in an APB read access cycle", $time);
    end
    @(negedge aclk);
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  // Expected answer of one command and its effect on the model memory
  function automatic cmdRespT refAccess(input logic wr, input logic [11:0] addr,
                                        input logic [31:0] data, input logic [3:0] strb);
    cmdRespT res;
    logic    inRange;
    inRange  = int'(addr) < `MEM_WORDS * 4;
    res.resp = inRange ? OKAY : SLVERR;
    res.data = '0;
    if (inRange && wr) begin
      for (int i = 0; i < 4; i++) begin
        if (strb[i]) begin
          modelMem[addr[9:2]][i*8 +: 8] = data[i*8 +: 8];
        end
      end
    end else if (inRange) begin
      res.data = modelMem[addr[9:2]];
    end
    return res;
  endfunction

  function automatic logic [31:0] fillWord(input logic [11:0] addr);
    return {~addr, 8'h3c, addr};
  endfunction

  task automatic startCmd(input logic wr, input logic [11:0] addr,
                          input logic [31:0] data, input logic [3:0] strb);
    logic err;
    apbWrite(`REG_ADDR, {20'h0, addr}, err);
    apbWrite(`REG_WDATA, data, err);
    apbWrite(`REG_CTRL, {24'h0, strb, 2'b00, wr, 1'b1}, err);
    checks++;
    if (err) begin
      errors++;
      $display("Error at %0t: CTRL go was rejected while idle", $time);
    end
  endtask

  task automatic finishCmd(input logic wr, input logic [11:0] addr,
                           input logic [31:0] data, input logic [3:0] strb);
    cmdRespT     want;
    cmdRespT     got;
    logic [31:0] st;
    logic [31:0] rd;
    logic        err;
    st = 32'h1;
    while (st[0]) begin
      apbRead(`REG_STATUS, st, err);
    end
    apbRead(`REG_RDATA, rd, err);
    want = refAccess(wr, addr, data, strb);
    // RDATA only moves on reads
    if (!wr) begin
      expRdata = want.data;
    end
    want.data = expRdata;
    got.resp  = respT'(st[2:1]);
    got.data  = rd;
    expQ.push_back(want);
    obsQ.push_back(got);
    tagQ.push_back(cmdCount);
    cmdCount++;
  endtask

  task automatic runCmd(input logic wr, input logic [11:0] addr,
                        input logic [31:0] data, input logic [3:0] strb);
    startCmd(wr, addr, data, strb);
    finishCmd(wr, addr, data, strb);
  endtask

  always @(negedge aclk) begin : compareBlk
    cmdRespT e;
    cmdRespT o;
    int      t;
    if (obsQ.size() > 0) begin
      e = expQ.pop_front();
      o = obsQ.pop_front();
      t = tagQ.pop_front();
      checks++;
      if (e != o) begin
        errors++;
        $display("Mismatch at %0t: command %0d expected resp %0d rdata %h, got resp %0d rdata %h",
                 $time, t, e.resp, e.data, o.resp, o.data);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    logic [31:0] rd;
    logic        err;
    logic        wr;
    logic [11:0] addr;
    aclk     = 1'b0;
    arstN    = 1'b0;
    apbReq   = '0;
    expRdata = '0;
    cmdCount = 0;
    checks   = 0;
    errors   = 0;
    cycles   = 0;
    void'($urandom(32'hbd4d));
    repeat (10) @(negedge aclk);
    arstN = 1'b1;

    apbRead(`REG_STATUS, rd, err);
    checks++;
    if (rd != 32'h0) begin
      errors++;
      $display("Mismatch at %0t: STATUS after reset is %h", $time, rd);
    end

    // Register read-back
    apbWrite(`REG_ADDR, 32'h0000_02a8, err);
    apbRead(`REG_ADDR, rd, err);
    checks++;
    if (rd != 32'h0000_02a8) begin
      errors++;
      $display("Mismatch at %0t: ADDR reads back %h", $time, rd);
    end
    apbWrite(`REG_WDATA, 32'hdead_beef, err);
    apbRead(`REG_WDATA, rd, err);
    checks++;
    if (rd != 32'hdead_beef) begin
      errors++;
      $display("Mismatch at %0t: WDATA reads back %h", $time, rd);
    end

    // Unmapped offset
    apbRead(8'h14, rd, err);
    checks++;
    if (!err) begin
      errors++;
      $display("Error at %0t: read of an unmapped offset gave no pslverr", $time);
    end

    // Full and partial strobes on word 16
    runCmd(1'b1, 12'h040, 32'h1234_5678, 4'hf);
    runCmd(1'b0, 12'h040, 32'h0, 4'h0);
    runCmd(1'b1, 12'h040, 32'haabb_ccdd, 4'b0101);
    runCmd(1'b0, 12'h040, 32'h0, 4'h0);

    // 0x440 aliases word 16 if the range check fails
    runCmd(1'b0, 12'h400, 32'h0, 4'h0);
    runCmd(1'b1, 12'h440, 32'hffff_ffff, 4'hf);
    runCmd(1'b0, 12'h040, 32'h0, 4'h0);

    // Go while busy must be refused and must not write
    startCmd(1'b0, 12'h040, 32'h5555_aaaa, 4'h0);
    apbWrite(`REG_CTRL, 32'h0000_00f3, err);
    checks++;
    if (!err) begin
      errors++;
      $display("Error at %0t: CTRL go while busy gave no pslverr", $time);
    end
    finishCmd(1'b0, 12'h040, 32'h5555_aaaa, 4'h0);
    runCmd(1'b0, 12'h040, 32'h0, 4'h0);

    for (int i = 0; i < WinWords; i++) begin
      runCmd(1'b1, 12'(i * 4), fillWord(12'(i * 4)), 4'hf);
    end

    for (int n = 0; n < NumRandom; n++) begin
      wr = 1'($urandom_range(1));
      if ($urandom_range(9) == 0) begin
        addr = 12'(32'h400 + ($urandom_range(767) << 2));
      end else begin
        addr = 12'($urandom_range(WinWords - 1) << 2);
      end
      runCmd(wr, addr, $urandom, 4'($urandom_range(15)));
    end

    while (obsQ.size() != 0) begin
      @(negedge aclk);
    end
    @(negedge aclk);
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* axiLiteSubsys.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axiLite_defs.svh"

module axiLiteSubsys import axiLitePkg::*; (
  input  logic   aclk,
  input  logic   arstN,
  input  apbReqT apbReq,
  output apbRspT apbRsp
);

  logic    cmdStart;
  cmdT     cmd;
  logic    cmdDone;
  cmdRespT cmdResp;

  // AXI4-Lite bus between master and slave
  logic    awValid;
  logic    awReady;
  awChanT  aw;
  logic    wValid;
  logic    wReady;
  wChanT   w;
  logic    bValid;
  logic    bReady;
  bChanT   b;
  logic    arValid;
  logic    arReady;
  arChanT  ar;
  logic    rValid;
  logic    rReady;
  rChanT   r;

  apbCmdRegs i_apbCmdRegs (
    .aclk(aclk), .arstN(arstN),
    .apbReq(apbReq), .apbRsp(apbRsp),
    .cmdStart(cmdStart), .cmd(cmd), .cmdDone(cmdDone), .cmdResp(cmdResp)
  );

  axiLiteMaster i_axiLiteMaster (
    .aclk(aclk), .arstN(arstN),
    .cmdStart(cmdStart), .cmd(cmd), .cmdDone(cmdDone), .cmdResp(cmdResp),
    .awValid(awValid), .awReady(awReady), .aw(aw),
    .wValid(wValid), .wReady(wReady), .w(w),
    .bValid(bValid), .bReady(bReady), .b(b),
    .arValid(arValid), .arReady(arReady), .ar(ar),
    .rValid(rValid), .rReady(rReady), .r(r)
  );

  axiLiteMemSlave i_axiLiteMemSlave (
    .aclk(aclk), .arstN(arstN),
    .awValid(awValid), .awReady(awReady), .aw(aw),
    .wValid(wValid), .wReady(wReady), .w(w),
    .bValid(bValid), .bReady(bReady), .b(b),
    .arValid(arValid), .arReady(arReady), .ar(ar),
    .rValid(rValid), .rReady(rReady), .r(r)
  );

endmodule

`default_nettype wire

/* axiLiteMemSlave.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axiLite_defs.svh"

module axiLiteMemSlave import axiLitePkg::*; (
  input  logic   aclk,
  input  logic   arstN,
  input  logic   awValid,
  output logic   awReady,
  input  awChanT aw,
  input  logic   wValid,
  output logic   wReady,
  input  wChanT  w,
  output logic   bValid,
  input  logic   bReady,
  output bChanT  b,
  input  logic   arValid,
  output logic   arReady,
  input  arChanT ar,
  output logic   rValid,
  input  logic   rReady,
  output rChanT  r
);

  localparam int IdxW     = $clog2(`MEM_WORDS);
  localparam int MemBytes = `MEM_WORDS * 4;

  logic                   awBufValid;
  awChanT                 awBuf;
  logic                   wBufValid;
  wChanT                  wBuf;
  logic                   arBufValid;
  arChanT                 arBuf;
  logic                   doWrite;
  logic                   doRead;
  logic                   wrInRange;
  logic                   rdInRange;
  logic [IdxW-1:0]        wrIdx;
  logic [IdxW-1:0]        rdIdx;
  logic [`AXI_DATA_W-1:0] mem [`MEM_WORDS];

  axiChanBuf #(.payloadT(awChanT)) i_awBuf (
    .aclk(aclk), .arstN(arstN),
    .inValid(awValid), .inReady(awReady), .inData(aw),
    .outValid(awBufValid), .outReady(doWrite), .outData(awBuf)
  );

  axiChanBuf #(.payloadT(wChanT)) i_wBuf (
    .aclk(aclk), .arstN(arstN),
    .inValid(wValid), .inReady(wReady), .inData(w),
    .outValid(wBufValid), .outReady(doWrite), .outData(wBuf)
  );

  axiChanBuf #(.payloadT(arChanT)) i_arBuf (
    .aclk(aclk), .arstN(arstN),
    .inValid(arValid), .inReady(arReady), .inData(ar),
    .outValid(arBufValid), .outReady(doRead), .outData(arBuf)
  );

  // Execute once the request is complete and the previous answer has gone
  assign doWrite   = awBufValid && wBufValid && !bValid;
  assign doRead    = arBufValid && !rValid;
  assign wrInRange = int'(awBuf.addr) < MemBytes;
  assign rdInRange = int'(arBuf.addr) < MemBytes;
  assign wrIdx     = awBuf.addr[IdxW+1:2];
  assign rdIdx     = arBuf.addr[IdxW+1:2];

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      bValid <= 1'b0;
      rValid <= 1'b0;
    end else begin
      if (doWrite) bValid <= 1'b1;
      else if (bReady) bValid <= 1'b0;
      if (doRead) rValid <= 1'b1;
      else if (rReady) rValid <= 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Memory and response payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk) begin
    if (doWrite) begin
      b.resp <= wrInRange ? OKAY : SLVERR;
      if (wrInRange) begin
        for (int i = 0; i < `AXI_STRB_W; i++) begin
          if (wBuf.strb[i]) mem[wrIdx][i*8 +: 8] <= wBuf.data[i*8 +: 8];
        end
      end
    end
    if (doRead) begin
      r.resp <= rdInRange ? OKAY : SLVERR;
      r.data <= rdInRange ? mem[rdIdx] : '0;
    end
  end

endmodule

`default_nettype wire

/* axiLiteMaster.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axiLite_defs.svh"

module axiLiteMaster import axiLitePkg::*; (
  input  logic    aclk,
  input  logic    arstN,
  input  logic    cmdStart,
  input  cmdT     cmd,
  output logic    cmdDone,
  output cmdRespT cmdResp,
  output logic    awValid,
  input  logic    awReady,
  output awChanT  aw,
  output logic    wValid,
  input  logic    wReady,
  output wChanT   w,
  input  logic    bValid,
  output logic    bReady,
  input  bChanT   b,
  output logic    arValid,
  input  logic    arReady,
  output arChanT  ar,
  input  logic    rValid,
  output logic    rReady,
  input  rChanT   r
);

  typedef enum logic [1:0] {
    stIdle,
    stAddr,
    stResp,
    stRdata
  } stateT;

  stateT state;
  cmdT   cmdQ;
  logic  awLeft;
  logic  wLeft;
  logic  arLeft;

  // Payloads come straight from the held command
  assign aw.addr = cmdQ.addr;
  assign w.data  = cmdQ.data;
  assign w.strb  = cmdQ.strb;
  assign ar.addr = cmdQ.addr;

  // Channels still waiting for their handshake
  assign awLeft = awValid && !awReady;
  assign wLeft  = wValid && !wReady;
  assign arLeft = arValid && !arReady;

  assign bReady  = state == stResp;
  assign rReady  = state == stRdata;
  assign cmdDone = (bReady && bValid) || (rReady && rValid);

  always_comb begin
    cmdResp.resp = b.resp;
    cmdResp.data = '0;
    if (state == stRdata) begin
      cmdResp.resp = r.resp;
      cmdResp.data = r.data;
    end
  end

  always_ff @(posedge aclk) begin
    if (state == stIdle && cmdStart) begin
      cmdQ <= cmd;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Transaction FSM, one command in flight
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      state   <= stIdle;
      awValid <= 1'b0;
      wValid  <= 1'b0;
      arValid <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (cmdStart) begin
            state   <= stAddr;
            awValid <= cmd.write;
            wValid  <= cmd.write;
            arValid <= !cmd.write;
          end
        end
        stAddr: begin
          // aw and w may finish in either order
          if (awReady) awValid <= 1'b0;
          if (wReady) wValid <= 1'b0;
          if (arReady) arValid <= 1'b0;
          if (!awLeft && !wLeft && !arLeft) begin
            state <= cmdQ.write ? stResp : stRdata;
          end
        end
        stResp: begin
          if (bValid) state <= stIdle;
        end
        stRdata: begin
          if (rValid) state <= stIdle;
        end
        default: state <= stIdle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* apbCmdRegs.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axiLite_defs.svh"

module apbCmdRegs import axiLitePkg::*; (
  input  logic    aclk,
  input  logic    arstN,
  input  apbReqT  apbReq,
  output apbRspT  apbRsp,
  output logic    cmdStart,
  output cmdT     cmd,
  input  logic    cmdDone,
  input  cmdRespT cmdResp
);

  logic                   access;
  logic                   isAddr;
  logic                   isWdata;
  logic                   isCtrl;
  logic                   isStatus;
  logic                   isRdata;
  logic                   mapped;
  logic                   goWhileBusy;
  logic                   wrOk;
  logic                   goAccept;
  logic [`AXI_ADDR_W-1:0] addrQ;
  logic [`AXI_DATA_W-1:0] wdataQ;
  logic [`AXI_DATA_W-1:0] rdataQ;
  logic                   busyQ;
  respT                   lastRespQ;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decode, the access cycle always completes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign access   = apbReq.psel && apbReq.penable;
  assign isAddr   = apbReq.paddr == `REG_ADDR;
  assign isWdata  = apbReq.paddr == `REG_WDATA;
  assign isCtrl   = apbReq.paddr == `REG_CTRL;
  assign isStatus = apbReq.paddr == `REG_STATUS;
  assign isRdata  = apbReq.paddr == `REG_RDATA;
  assign mapped   = isAddr || isWdata || isCtrl || isStatus || isRdata;

  assign goWhileBusy = isCtrl && apbReq.pwrite && apbReq.pwdata[`CTRL_GO_BIT] && busyQ;
  assign wrOk        = access && apbReq.pwrite && mapped && !goWhileBusy;
  assign goAccept    = wrOk && isCtrl && apbReq.pwdata[`CTRL_GO_BIT];

  always_comb begin
    apbRsp.pready  = 1'b1;
    apbRsp.pslverr = access && (!mapped || goWhileBusy);
    apbRsp.prdata  = '0;
    if (isAddr) begin
      apbRsp.prdata = `AXI_DATA_W'(addrQ);
    end else if (isWdata) begin
      apbRsp.prdata = wdataQ;
    end else if (isStatus) begin
      apbRsp.prdata = `AXI_DATA_W'({lastRespQ, busyQ});
    end else if (isRdata) begin
      apbRsp.prdata = rdataQ;
    end
  end

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      addrQ     <= '0;
      wdataQ    <= '0;
      rdataQ    <= '0;
      busyQ     <= 1'b0;
      lastRespQ <= OKAY;
      cmdStart  <= 1'b0;
    end else begin
      cmdStart <= goAccept;
      if (wrOk && isAddr) begin
        addrQ <= apbReq.pwdata[`AXI_ADDR_W-1:0];
      end
      if (wrOk && isWdata) begin
        wdataQ <= apbReq.pwdata;
      end
      if (goAccept) begin
        busyQ <= 1'b1;
      end else if (cmdDone) begin
        busyQ     <= 1'b0;
        lastRespQ <= cmdResp.resp;
        // A failed read leaves zero behind
        if (!cmd.write) begin
          rdataQ <= (cmdResp.resp == SLVERR) ? '0 : cmdResp.data;
        end
      end
    end
  end

  // Command snapshot, taken with the go bit
  always_ff @(posedge aclk) begin
    if (goAccept) begin
      cmd.write <= apbReq.pwdata[`CTRL_WRITE_BIT];
      cmd.addr  <= addrQ;
      cmd.data  <= wdataQ;
      cmd.strb  <= apbReq.pwdata[`CTRL_STRB_LSB +: `AXI_STRB_W];
    end
  end

endmodule

`default_nettype wire

/* axiChanBuf.sv */
`timescale 1ns/10ps
`default_nettype none

`include "axiLite_defs.svh"

module axiChanBuf import axiLitePkg::*; #(
  parameter type payloadT = awChanT
) (
  input  logic    aclk,
  input  logic    arstN,
  input  logic    inValid,
  output logic    inReady,
  input  payloadT inData,
  output logic    outValid,
  input  logic    outReady,
  output payloadT outData
);

  logic    full;
  payloadT dataQ;

  // Accept while empty, or while the held entry leaves this cycle
  assign inReady  = !full || outReady;
  assign outValid = full;
  assign outData  = dataQ;

  always_ff @(posedge aclk or negedge arstN) begin
    if (!arstN) begin
      full <= 1'b0;
    end else if (inValid && inReady) begin
      full <= 1'b1;
    end else if (outReady) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (inValid && inReady) begin
      dataQ <= inData;
    end
  end

endmodule

`default_nettype wire

/* axiLitePkg.sv */
`default_nettype none

`include "axiLite_defs.svh"

package axiLitePkg;

  // AXI response codes, EXOKAY and DECERR are never produced
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } respT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite channel payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
  } awChanT;

  typedef struct packed {
    logic [`AXI_ADDR_W-1:0] addr;
  } arChanT;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } wChanT;

  typedef struct packed {
    respT resp;
  } bChanT;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] data;
    respT                   resp;
  } rChanT;

  // Command from the register block and the answer from the master
  typedef struct packed {
    logic                   write;
    logic [`AXI_ADDR_W-1:0] addr;
    logic [`AXI_DATA_W-1:0] data;
    logic [`AXI_STRB_W-1:0] strb;
  } cmdT;

  typedef struct packed {
    respT                   resp;
    logic [`AXI_DATA_W-1:0] data;
  } cmdRespT;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // APB
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [`APB_ADDR_W-1:0] paddr;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`AXI_DATA_W-1:0] pwdata;
  } apbReqT;

  typedef struct packed {
    logic [`AXI_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
  } apbRspT;

endpackage

`default_nettype wire

/* axiLite_defs.svh */
`ifndef AXILITE_DEFS_SVH
`define AXILITE_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite bus widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define AXI_ADDR_W 12
`define AXI_DATA_W 32
`define AXI_STRB_W (`AXI_DATA_W / 8)

// Slave memory depth in words, byte addresses from 1024 up are out of range
`define MEM_WORDS 256

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB control port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define APB_ADDR_W 8

// Register offsets
`define REG_ADDR   8'h00
`define REG_WDATA  8'h04
`define REG_CTRL   8'h08
`define REG_STATUS 8'h0C
`define REG_RDATA  8'h10

// CTRL fields
`define CTRL_GO_BIT    0
`define CTRL_WRITE_BIT 1
`define CTRL_STRB_LSB  4

`endif
